// File: sched_cfg_pkg.sv
package sched_cfg_pkg;

  // Scheduler sizes
  localparam int core_count     = 4;
  localparam int slot_count     = 8;

  // Holds counts 0..slot_count and slot ids 1..slot_count
  localparam int slot_width     = 4;
  localparam int slot_ptr_width = 3;
  localparam int core_id_width  = 2;

  // Ethernet side
  localparam int if_count       = 2;
  localparam int if_width       = 1;
  localparam int data_width     = 64;
  localparam int keep_width     = data_width / 8;

  typedef logic [core_count-1:0] core_mask_t;
  typedef logic [if_count-1:0]   if_mask_t;

endpackage

// File: sched_msg_pkg.sv
package sched_msg_pkg;

  // Control message types from cores
  localparam logic [3:0] msg_slot_free = 4'd0;
  localparam logic [3:0] msg_slot_init = 4'd3;

  // Scheduler register addresses
  localparam logic [2:0] addr_income    = 3'd0;
  localparam logic [2:0] addr_enable    = 3'd1;
  localparam logic [2:0] addr_count     = 3'd2;
  localparam logic [2:0] addr_if_enable = 3'd5;

  localparam logic [31:0] rd_default = 32'hFEFE_FEFE;

  // Core and slot, sent as tdest
  typedef struct packed {
    logic [sched_cfg_pkg::core_id_width-1:0] core;
    logic [sched_cfg_pkg::slot_width-1:0]    slot;
  } desc_t;

  typedef struct packed {
    logic [3:0]  msg_type;
    logic [11:0] zero;
    logic [3:0]  slot;
    logic [15:0] unused;
  } ctrl_msg_t;

  typedef struct packed {
    logic        wr;
    logic        sched;
    logic [2:0]  addr;
    logic [24:0] zero;
    logic [1:0]  index;
  } host_cmd_t;

  typedef struct packed {
    logic [sched_cfg_pkg::data_width-1:0] data;
    logic [sched_cfg_pkg::keep_width-1:0] keep;
    logic                                 last;
  } axis_beat_t;

  typedef struct packed {
    axis_beat_t                         beat;
    desc_t                              dest;
    logic [sched_cfg_pkg::if_width-1:0] user;
  } tagged_beat_t;

endpackage

// File: ctrl_decode.sv
module ctrl_decode (
  input  logic                                                       clk,
  input  logic                                                       rst_r,
  input  sched_msg_pkg::host_cmd_t                                   host_cmd,
  input  logic [31:0]                                                host_wr_data,
  input  logic                                                       host_valid,
  input  sched_msg_pkg::ctrl_msg_t                                   ctrl_msg,
  input  logic [sched_cfg_pkg::core_id_width-1:0]                    ctrl_src,
  input  logic                                                       ctrl_valid,
  input  logic [sched_cfg_pkg::core_count-1:0][sched_cfg_pkg::slot_width-1:0] slot_counts,
  output logic [31:0]                                                host_rd_data,
  output logic                                                       ctrl_ready,
  output sched_cfg_pkg::core_mask_t                                  slot_free_v,
  output sched_cfg_pkg::core_mask_t                                  slot_init_v,
  output logic [sched_cfg_pkg::slot_width-1:0]                       slot_val,
  output sched_cfg_pkg::core_mask_t                                  income_cores,
  output sched_cfg_pkg::core_mask_t                                  enabled_cores,
  output sched_cfg_pkg::if_mask_t                                    enabled_ifs
);
  import sched_cfg_pkg::*;
  import sched_msg_pkg::*;

  host_cmd_t   cmd_r;
  logic [31:0] wr_data_r;
  logic        sched_wr_r;

  // Every message type is taken, unknown ones are dropped
  assign ctrl_ready = 1'b1;

  always_ff @(posedge clk) begin
    cmd_r     <= host_cmd;
    wr_data_r <= host_wr_data;
    if (rst_r)
      sched_wr_r <= 1'b0;
    else
      sched_wr_r <= host_valid && host_cmd.wr && host_cmd.sched;
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      income_cores  <= '0;
      enabled_cores <= '0;
      enabled_ifs   <= '0;
    end else if (sched_wr_r) begin
      case (cmd_r.addr)
        // A disabled core never takes new packets
        addr_income: income_cores <= wr_data_r[core_count-1:0] & enabled_cores;
        addr_enable: begin
          enabled_cores <= wr_data_r[core_count-1:0];
          income_cores  <= income_cores & wr_data_r[core_count-1:0];
        end
        addr_if_enable: enabled_ifs <= wr_data_r[if_count-1:0];
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (cmd_r.addr)
      addr_income:    host_rd_data <= 32'(income_cores);
      addr_enable:    host_rd_data <= 32'(enabled_cores);
      addr_count:     host_rd_data <= 32'(slot_counts[cmd_r.index]);
      addr_if_enable: host_rd_data <= 32'(enabled_ifs);
      default:        host_rd_data <= rd_default;
    endcase
  end

  // One-hot strobes towards the slot queues
  always_ff @(posedge clk) begin
    slot_val <= ctrl_msg.slot;
    if (rst_r) begin
      slot_free_v <= '0;
      slot_init_v <= '0;
    end else begin
      slot_free_v <= '0;
      slot_init_v <= '0;
      if (ctrl_valid && (ctrl_msg.msg_type == msg_slot_free))
        slot_free_v[ctrl_src] <= 1'b1;
      if (ctrl_valid && (ctrl_msg.msg_type == msg_slot_init))
        slot_init_v[ctrl_src] <= 1'b1;
    end
  end

endmodule

// File: slot_store.sv
module slot_store (
  input  logic                                                       clk,
  input  logic                                                       rst_r,
  input  sched_cfg_pkg::core_mask_t                                  slot_free_v,
  input  sched_cfg_pkg::core_mask_t                                  slot_init_v,
  input  logic [sched_cfg_pkg::slot_width-1:0]                       slot_val,
  input  logic                                                       desc_pop,
  input  logic [sched_cfg_pkg::core_id_width-1:0]                    pop_core,
  output logic [sched_cfg_pkg::core_count-1:0][sched_cfg_pkg::slot_width-1:0] slot_head,
  output sched_cfg_pkg::core_mask_t                                  slot_avail,
  output logic [sched_cfg_pkg::core_count-1:0][sched_cfg_pkg::slot_width-1:0] slot_counts,
  output logic                                                       overflow
);
  import sched_cfg_pkg::*;

  logic [slot_width-1:0]                     mem [core_count][slot_count];
  logic [core_count-1:0][slot_ptr_width-1:0] head;
  logic [core_count-1:0][slot_ptr_width-1:0] tail;
  logic [core_count-1:0][slot_width-1:0]     count;
  logic [slot_width-1:0]                     init_len;
  core_mask_t                                full;
  core_mask_t                                do_push;
  core_mask_t                                do_pop;

  // Init larger than the queue is clipped
  assign init_len = (slot_val > slot_width'(slot_count)) ? slot_width'(slot_count) : slot_val;

  always_comb begin
    for (int i = 0; i < core_count; i++) begin
      full[i]       = count[i] == slot_width'(slot_count);
      do_push[i]    = slot_free_v[i] && !full[i];
      do_pop[i]     = desc_pop && (pop_core == core_id_width'(i)) && (count[i] != '0);
      slot_head[i]  = mem[i][head[i]];
      slot_avail[i] = count[i] != '0;
    end
  end

  assign slot_counts = count;

  always_ff @(posedge clk) begin
    for (int i = 0; i < core_count; i++) begin
      if (slot_init_v[i]) begin
        for (int k = 0; k < slot_count; k++)
          mem[i][k] <= slot_width'(k + 1);
      end else if (do_push[i]) begin
        mem[i][tail[i]] <= slot_val;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      head     <= '0;
      tail     <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      overflow <= |(slot_free_v & ~slot_init_v & full);
      for (int i = 0; i < core_count; i++) begin
        if (slot_init_v[i]) begin
          head[i]  <= '0;
          tail[i]  <= slot_ptr_width'(init_len);
          count[i] <= init_len;
        end else begin
          if (do_push[i])
            tail[i] <= tail[i] + 1'b1;
          if (do_pop[i])
            head[i] <= head[i] + 1'b1;
          count[i] <= count[i] + slot_width'(do_push[i]) - slot_width'(do_pop[i]);
        end
      end
    end
  end

endmodule

// File: core_select.sv
module core_select (
  input  logic [sched_cfg_pkg::core_count-1:0][sched_cfg_pkg::slot_width-1:0] slot_counts,
  input  logic [sched_cfg_pkg::core_count-1:0][sched_cfg_pkg::slot_width-1:0] slot_head,
  input  sched_cfg_pkg::core_mask_t                                  slot_avail,
  input  sched_cfg_pkg::core_mask_t                                  income_cores,
  input  sched_cfg_pkg::core_mask_t                                  enabled_cores,
  output sched_msg_pkg::desc_t                                       cand_desc,
  output logic                                                       cand_valid
);
  import sched_cfg_pkg::*;
  import sched_msg_pkg::*;

  core_mask_t               eligible;
  logic [core_id_width-1:0] best;
  logic                     found;

  assign eligible = income_cores & enabled_cores & slot_avail;

  // Strict compare keeps the lowest index on a tie
  always_comb begin
    best  = '0;
    found = 1'b0;
    for (int i = 0; i < core_count; i++) begin
      if (eligible[i] && (!found || (slot_counts[i] > slot_counts[best]))) begin
        best  = core_id_width'(i);
        found = 1'b1;
      end
    end
  end

  always_comb begin
    cand_desc.core = best;
    cand_desc.slot = slot_head[best];
    cand_valid     = found;
  end

endmodule

// File: port_tagger.sv
module port_tagger (
  input  logic                                                      clk,
  input  logic                                                      rst_r,
  input  sched_msg_pkg::axis_beat_t [sched_cfg_pkg::if_count-1:0]   rx_beat,
  input  sched_cfg_pkg::if_mask_t                                   rx_valid,
  output sched_cfg_pkg::if_mask_t                                   rx_ready,
  output sched_msg_pkg::tagged_beat_t [sched_cfg_pkg::if_count-1:0] tx_beat,
  output sched_cfg_pkg::if_mask_t                                   tx_valid,
  input  sched_cfg_pkg::if_mask_t                                   tx_ready,
  input  sched_cfg_pkg::if_mask_t                                   enabled_ifs,
  input  sched_msg_pkg::desc_t                                      cand_desc,
  input  logic                                                      cand_valid,
  output logic                                                      desc_pop,
  output logic [sched_cfg_pkg::core_id_width-1:0]                   pop_core
);
  import sched_cfg_pkg::*;
  import sched_msg_pkg::*;

  typedef enum logic [1:0] {
    st_stall = 2'b00,
    st_first = 2'b01,
    st_wait  = 2'b10,
    st_mid   = 2'b11
  } port_state_t;

  port_state_t         state [if_count];
  // Descriptor for the next packet
  desc_t               dest_r [if_count];
  // Descriptor of the packet in flight
  desc_t               dest_rr [if_count];
  if_mask_t            port_open;
  if_mask_t            port_valid;
  if_mask_t            port_last;
  if_mask_t            desc_req;
  if_mask_t            port_desc_avail;
  logic [if_width-1:0] rr_last;
  logic [if_width-1:0] grant_idx;
  logic                grant_v;

  always_comb begin
    for (int p = 0; p < if_count; p++) begin
      port_open[p]  = (state[p] != st_stall) && enabled_ifs[p];
      rx_ready[p]   = tx_ready[p] && port_open[p];
      tx_valid[p]   = rx_valid[p] && port_open[p];
      port_valid[p] = rx_valid[p] && rx_ready[p];
      port_last[p]  = port_valid[p] && rx_beat[p].last;
      // Ask for the next descriptor as soon as the current one is used
      desc_req[p]   = enabled_ifs[p] &&
                      ((state[p] == st_stall) || (state[p] == st_wait) ||
                       ((state[p] == st_first) && port_valid[p]));
      tx_beat[p].beat = rx_beat[p];
      tx_beat[p].dest = (state[p] == st_first) ? dest_r[p] : dest_rr[p];
      tx_beat[p].user = if_width'(p);
    end
  end

  // Round-robin search from the interface after the last grant
  always_comb begin
    int idx;
    grant_idx = rr_last;
    grant_v   = 1'b0;
    for (int k = 1; k <= if_count; k++) begin
      idx = (int'(rr_last) + k) % if_count;
      if (!grant_v && desc_req[idx]) begin
        grant_idx = if_width'(idx);
        grant_v   = 1'b1;
      end
    end
  end

  assign desc_pop = grant_v && cand_valid;
  assign pop_core = cand_desc.core;

  always_comb begin
    for (int p = 0; p < if_count; p++)
      port_desc_avail[p] = desc_pop && (grant_idx == if_width'(p));
  end

  always_ff @(posedge clk) begin
    if (rst_r)
      rr_last <= if_width'(if_count - 1);
    else if (desc_pop)
      rr_last <= grant_idx;
  end

  always_ff @(posedge clk) begin
    for (int p = 0; p < if_count; p++) begin
      if (port_desc_avail[p])
        dest_r[p] <= cand_desc;
      if ((state[p] == st_first) && port_valid[p])
        dest_rr[p] <= dest_r[p];
    end
  end

  always_ff @(posedge clk) begin
    for (int p = 0; p < if_count; p++) begin
      if (rst_r) begin
        state[p] <= st_stall;
      end else begin
        case (state[p])
          st_stall: if (port_desc_avail[p]) state[p] <= st_first;
          st_first: begin
            // A grant here can only come with the first beat
            if (port_desc_avail[p])
              state[p] <= port_last[p] ? st_first : st_mid;
            else if (port_valid[p])
              state[p] <= port_last[p] ? st_stall : st_wait;
          end
          st_wait: begin
            if (port_desc_avail[p])
              state[p] <= port_last[p] ? st_first : st_mid;
            else if (port_last[p])
              state[p] <= st_stall;
          end
          st_mid: if (port_last[p]) state[p] <= st_first;
          default: state[p] <= st_stall;
        endcase
      end
    end
  end

endmodule

// File: rx_scheduler.sv
module rx_scheduler (
  input  logic                                                      clk,
  input  logic                                                      rst_r,
  input  sched_msg_pkg::host_cmd_t                                  host_cmd,
  input  logic [31:0]                                               host_wr_data,
  input  logic                                                      host_valid,
  output logic [31:0]                                               host_rd_data,
  input  sched_msg_pkg::ctrl_msg_t                                  ctrl_msg,
  input  logic [sched_cfg_pkg::core_id_width-1:0]                   ctrl_src,
  input  logic                                                      ctrl_valid,
  output logic                                                      ctrl_ready,
  input  sched_msg_pkg::axis_beat_t [sched_cfg_pkg::if_count-1:0]   rx_beat,
  input  sched_cfg_pkg::if_mask_t                                   rx_valid,
  output sched_cfg_pkg::if_mask_t                                   rx_ready,
  output sched_msg_pkg::tagged_beat_t [sched_cfg_pkg::if_count-1:0] tx_beat,
  output sched_cfg_pkg::if_mask_t                                   tx_valid,
  input  sched_cfg_pkg::if_mask_t                                   tx_ready
);
  import sched_cfg_pkg::*;
  import sched_msg_pkg::*;

  core_mask_t                            slot_free_v;
  core_mask_t                            slot_init_v;
  logic [slot_width-1:0]                 slot_val;
  core_mask_t                            income_cores;
  core_mask_t                            enabled_cores;
  if_mask_t                              enabled_ifs;
  logic [core_count-1:0][slot_width-1:0] slot_head;
  core_mask_t                            slot_avail;
  logic [core_count-1:0][slot_width-1:0] slot_counts;
  desc_t                                 cand_desc;
  logic                                  cand_valid;
  logic                                  desc_pop;
  logic [core_id_width-1:0]              pop_core;

  ctrl_decode u_ctrl_decode (
    .clk          (clk),
    .rst_r        (rst_r),
    .host_cmd     (host_cmd),
    .host_wr_data (host_wr_data),
    .host_valid   (host_valid),
    .ctrl_msg     (ctrl_msg),
    .ctrl_src     (ctrl_src),
    .ctrl_valid   (ctrl_valid),
    .slot_counts  (slot_counts),
    .host_rd_data (host_rd_data),
    .ctrl_ready   (ctrl_ready),
    .slot_free_v  (slot_free_v),
    .slot_init_v  (slot_init_v),
    .slot_val     (slot_val),
    .income_cores (income_cores),
    .enabled_cores(enabled_cores),
    .enabled_ifs  (enabled_ifs)
  );

  // Overflow is watched by the bound checks only
  slot_store u_slot_store (
    .clk        (clk),
    .rst_r      (rst_r),
    .slot_free_v(slot_free_v),
    .slot_init_v(slot_init_v),
    .slot_val   (slot_val),
    .desc_pop   (desc_pop),
    .pop_core   (pop_core),
    .slot_head  (slot_head),
    .slot_avail (slot_avail),
    .slot_counts(slot_counts),
    .overflow   ()
  );

  core_select u_core_select (
    .slot_counts  (slot_counts),
    .slot_head    (slot_head),
    .slot_avail   (slot_avail),
    .income_cores (income_cores),
    .enabled_cores(enabled_cores),
    .cand_desc    (cand_desc),
    .cand_valid   (cand_valid)
  );

  port_tagger u_port_tagger (
    .clk        (clk),
    .rst_r      (rst_r),
    .rx_beat    (rx_beat),
    .rx_valid   (rx_valid),
    .rx_ready   (rx_ready),
    .tx_beat    (tx_beat),
    .tx_valid   (tx_valid),
    .tx_ready   (tx_ready),
    .enabled_ifs(enabled_ifs),
    .cand_desc  (cand_desc),
    .cand_valid (cand_valid),
    .desc_pop   (desc_pop),
    .pop_core   (pop_core)
  );

endmodule

// File: rx_scheduler_properties.sv
module rx_scheduler_properties (
  input logic                                                      clk,
  input logic                                                      rst_r,
  input logic                                                      ctrl_ready,
  input sched_cfg_pkg::if_mask_t                                   tx_valid,
  input sched_cfg_pkg::if_mask_t                                   tx_ready,
  input sched_cfg_pkg::if_mask_t                                   enabled_ifs,
  input sched_msg_pkg::tagged_beat_t [sched_cfg_pkg::if_count-1:0] tx_beat,
  input logic                                                      overflow
);
  import sched_cfg_pkg::*;

  a_ctrl_ready: assert property (@(posedge clk) disable iff (rst_r) ctrl_ready)
    else $error("ctrl_ready went low");

  a_valid_enabled: assert property (@(posedge clk) disable iff (rst_r)
    (tx_valid & ~enabled_ifs) == '0)
    else $error("tx_valid on a disabled interface");

  a_no_overflow: assert property (@(posedge clk) disable iff (rst_r) !overflow)
    else $error("free slot queue overflow");

  // Stalled beat must not change
  for (genvar p = 0; p < if_count; p++) begin : g_hold
    a_beat_hold: assert property (@(posedge clk) disable iff (rst_r)
      (tx_valid[p] && !tx_ready[p]) |=> $stable(tx_beat[p]))
      else $error("tx_beat changed under back-pressure");
  end

endmodule

bind rx_scheduler rx_scheduler_properties props0 (
  .clk        (clk),
  .rst_r      (rst_r),
  .ctrl_ready (ctrl_ready),
  .tx_valid   (tx_valid),
  .tx_ready   (tx_ready),
  .enabled_ifs(enabled_ifs),
  .tx_beat    (tx_beat),
  .overflow   (u_slot_store.overflow)
);

// File: tb_rx_scheduler.sv
module tb_rx_scheduler;
  import sched_cfg_pkg::*;
  import sched_msg_pkg::*;

  localparam int step_cycles = 300;

  typedef enum logic [2:0] {k_wr, k_rd, k_msg, k_pkt, k_block} step_kind_t;

  typedef struct packed {
    step_kind_t  kind;
    logic [2:0]  addr;
    logic [3:0]  mtype;
    logic [1:0]  idx;
    logic [31:0] val;
  } step_t;

  logic clk;
  logic rst_r;
  host_cmd_t host_cmd;
  logic [31:0] host_wr_data;
  logic host_valid;
  logic [31:0] host_rd_data;
  ctrl_msg_t ctrl_msg;
  logic [core_id_width-1:0] ctrl_src;
  logic ctrl_valid;
  logic ctrl_ready;
  axis_beat_t [if_count-1:0] rx_beat;
  if_mask_t rx_valid;
  if_mask_t rx_ready;
  tagged_beat_t [if_count-1:0] tx_beat;
  if_mask_t tx_valid;
  if_mask_t tx_ready;

  step_t steps[$];
  string names[$];
  int errors;
  int seed_val;

  // Reference model of registers, slot queues and prefetched descriptors
  int q[core_count][$];
  logic [3:0] m_income;
  logic [3:0] m_enable;
  logic [1:0] m_ifen;
  bit held_v[if_count];
  desc_t held[if_count];
  int rr;

  rx_scheduler dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic add(input step_kind_t kind, input string name, input logic [2:0] addr,
                     input logic [3:0] mtype, input logic [1:0] idx, input logic [31:0] val);
    step_t s;
    s.kind = kind;
    s.addr = addr;
    s.mtype = mtype;
    s.idx = idx;
    s.val = val;
    steps.push_back(s);
    names.push_back(name);
  endtask

  function automatic void refill();
    bit popped;
    int p;
    int best;
    popped = 1'b1;
    while (popped) begin
      popped = 1'b0;
      for (int k = 1; k <= if_count; k++) begin
        p = (rr + k) % if_count;
        if (!popped && m_ifen[p] && !held_v[p]) begin
          best = -1;
          for (int i = 0; i < core_count; i++)
            if (m_income[i] && m_enable[i] && q[i].size() > 0 &&
                (best < 0 || q[i].size() > q[best].size()))
              best = i;
          // Only the first lacking interface asks in a cycle
          if (best >= 0) begin
            held[p].core = core_id_width'(best);
            held[p].slot = slot_width'(q[best].pop_front());
            held_v[p] = 1'b1;
            rr = p;
            popped = 1'b1;
          end
        end
      end
    end
  endfunction

  task automatic do_write(input step_t s);
    host_cmd_t c;
    c = '0;
    c.wr = 1'b1;
    c.sched = 1'b1;
    c.addr = s.addr;
    c.index = s.idx;
    host_cmd <= c;
    host_wr_data <= s.val;
    host_valid <= 1'b1;
    @(posedge clk);
    host_valid <= 1'b0;
    case (s.addr)
      addr_income: m_income = s.val[3:0] & m_enable;
      addr_enable: begin
        m_enable = s.val[3:0];
        m_income = m_income & s.val[3:0];
      end
      addr_if_enable: m_ifen = s.val[1:0];
      default: ;
    endcase
  endtask

  task automatic do_read(input step_t s, input string name);
    host_cmd_t c;
    logic [31:0] exp;
    c = '0;
    c.addr = s.addr;
    c.index = s.idx;
    host_cmd <= c;
    case (s.addr)
      addr_income: exp = 32'(m_income);
      addr_enable: exp = 32'(m_enable);
      addr_count: exp = 32'(q[s.idx].size());
      addr_if_enable: exp = 32'(m_ifen);
      default: exp = 32'hFEFE_FEFE;
    endcase
    // Read data follows the command by two edges
    repeat (2) @(posedge clk);
    @(negedge clk);
    assert (host_rd_data == exp) else begin
      $display("FAILED %s expected %h actual %h", name, exp, host_rd_data);
      errors++;
    end
  endtask

  task automatic do_msg(input step_t s);
    ctrl_msg_t m;
    m = '0;
    m.msg_type = s.mtype;
    m.slot = s.val[3:0];
    ctrl_msg <= m;
    ctrl_src <= s.idx;
    ctrl_valid <= 1'b1;
    @(posedge clk);
    ctrl_valid <= 1'b0;
    if (s.mtype == msg_slot_init) begin
      q[s.idx].delete();
      for (int k = 1; k <= s.val && k <= slot_count; k++)
        q[s.idx].push_back(k);
    end else if (s.mtype == msg_slot_free && q[s.idx].size() < slot_count) begin
      q[s.idx].push_back(int'(s.val[3:0]));
    end
  endtask

  task automatic send_packet(input int p, input int len, input string name);
    axis_beat_t b;
    tagged_beat_t exp;
    desc_t d;
    int n;
    d = held[p];
    held_v[p] = 1'b0;
    refill();
    n = 0;
    b = {$urandom, $urandom, 8'($urandom), len == 1};
    rx_beat[p] <= b;
    rx_valid[p] <= 1'b1;
    tx_ready[p] <= ($urandom % 4) != 0;
    while (n < len) begin
      @(negedge clk);
      if (rx_ready[p]) begin
        exp.beat = b;
        exp.dest = d;
        exp.user = if_width'(p);
        assert (tx_valid[p] && tx_beat[p] == exp) else begin
          $display("FAILED %s expected %h actual %h", name, exp, tx_beat[p]);
          errors++;
        end
        n++;
        b = {$urandom, $urandom, 8'($urandom), n == len - 1};
      end
      @(posedge clk);
      rx_beat[p] <= b;
      tx_ready[p] <= ($urandom % 4) != 0;
    end
    rx_valid[p] <= 1'b0;
    tx_ready[p] <= 1'b1;
  endtask

  task automatic check_blocked(input int p);
    rx_valid[p] <= 1'b1;
    rx_beat[p] <= {$urandom, $urandom, 8'hff, 1'b1};
    repeat (10) begin
      @(negedge clk);
      assert (!tx_valid[p] && !rx_ready[p]) else begin
        $display("Interface %0d let a beat through while it was blocked", p);
        errors++;
      end
      @(posedge clk);
    end
    rx_valid[p] <= 1'b0;
  endtask

  task automatic build_table();
    add(k_wr, "enable cores 0-2", addr_enable, 0, 0, 32'h7);
    add(k_wr, "income all", addr_income, 0, 0, 32'hf);
    add(k_rd, "income masked", addr_income, 0, 0, 0);
    add(k_msg, "init core0", 0, msg_slot_init, 0, 3);
    add(k_msg, "init core1", 0, msg_slot_init, 1, 5);
    add(k_msg, "init core2", 0, msg_slot_init, 2, 2);
    add(k_rd, "count core0", addr_count, 0, 0, 0);
    add(k_rd, "count core1", addr_count, 0, 1, 0);
    add(k_rd, "count core2", addr_count, 0, 2, 0);
    add(k_wr, "disable core1", addr_enable, 0, 0, 32'h5);
    add(k_rd, "income after disable", addr_income, 0, 0, 0);
    add(k_rd, "enable readback", addr_enable, 0, 0, 0);
    add(k_wr, "enable cores again", addr_enable, 0, 0, 32'h7);
    add(k_wr, "income cores 0-2", addr_income, 0, 0, 32'h7);
    add(k_wr, "enable if0", addr_if_enable, 0, 0, 32'h1);
    add(k_rd, "if enable readback", addr_if_enable, 0, 0, 0);
    add(k_rd, "unknown address", 3'd3, 0, 0, 0);
    add(k_pkt, "packet if0 len3", 0, 0, 0, 3);
    add(k_rd, "count core1 after packet", addr_count, 0, 1, 0);
    add(k_msg, "free slot1 core1", 0, msg_slot_free, 1, 1);
    add(k_rd, "count core1 after free", addr_count, 0, 1, 0);
    add(k_wr, "enable both ifs", addr_if_enable, 0, 0, 32'h3);
    add(k_pkt, "packet if1 len2", 0, 0, 1, 2);
    add(k_pkt, "packet if0 len4", 0, 0, 0, 4);
    add(k_pkt, "packet if1 len1", 0, 0, 1, 1);
    add(k_pkt, "packet if0 len5", 0, 0, 0, 5);
    add(k_pkt, "packet if1 len3", 0, 0, 1, 3);
    add(k_wr, "income none", addr_income, 0, 0, 32'h0);
    add(k_pkt, "packet if0 held", 0, 0, 0, 2);
    add(k_pkt, "packet if1 held", 0, 0, 1, 2);
    add(k_block, "if0 no eligible core", 0, 0, 0, 0);
    add(k_wr, "disable if0", addr_if_enable, 0, 0, 32'h2);
    add(k_msg, "init core3", 0, msg_slot_init, 3, 4);
    add(k_block, "if1 no eligible core", 0, 0, 1, 0);
    add(k_wr, "enable all cores", addr_enable, 0, 0, 32'hf);
    add(k_wr, "income core3", addr_income, 0, 0, 32'h8);
    add(k_pkt, "packet if1 core3", 0, 0, 1, 2);
    add(k_wr, "disable if1", addr_if_enable, 0, 0, 32'h0);
    add(k_block, "if1 disabled with descriptor", 0, 0, 1, 0);
    add(k_rd, "count core3", addr_count, 0, 3, 0);
  endtask

  initial begin
    int fails_before;
    seed_val = $urandom(54);
    rst_r = 1'b1;
    host_cmd = '0;
    host_wr_data = '0;
    host_valid = 1'b0;
    ctrl_msg = '0;
    ctrl_src = '0;
    ctrl_valid = 1'b0;
    rx_beat = '0;
    rx_valid = '0;
    tx_ready = '1;
    errors = 0;
    m_income = '0;
    m_enable = '0;
    m_ifen = '0;
    rr = if_count - 1;
    held_v[0] = 1'b0;
    held_v[1] = 1'b0;
    build_table();
    fork
      begin
        #(steps.size() * step_cycles * 8 + 200);
        $display("Watchdog expired before all steps finished");
        $display("SIMULATION FAILED");
        $finish;
      end
    join_none
    repeat (16) @(posedge clk);
    rst_r <= 1'b0;
    @(posedge clk);
    foreach (steps[i]) begin
      fails_before = errors;
      case (steps[i].kind)
        k_wr: do_write(steps[i]);
        k_rd: do_read(steps[i], names[i]);
        k_msg: do_msg(steps[i]);
        k_pkt: send_packet(int'(steps[i].idx), int'(steps[i].val), names[i]);
        default: check_blocked(int'(steps[i].idx));
      endcase
      refill();
      repeat (4) @(posedge clk);
      $display("step %0d %s: %s", i, names[i], (errors == fails_before) ? "ok" : "error");
    end
    $display("steps %0d, failed checks %0d", steps.size(), errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: vlog.f
sched_cfg_pkg.sv
sched_msg_pkg.sv
ctrl_decode.sv
slot_store.sv
core_select.sv
port_tagger.sv
rx_scheduler.sv
rx_scheduler_properties.sv
tb_rx_scheduler.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_rx_scheduler -f vlog.f -o sim_rx_scheduler
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_rx_scheduler > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "SIMULATION FAILED" sim.log; then
  exit 1
fi
exit 0
